// ==== list.f ====
hl_pkg.sv
cmd_ctrl.sv
cfg_regs.sv
status_monitor.sv
resp_builder.sv
hl_ctrl_top.sv
tb_clk_gen.sv
tb_hl_ctrl.sv

// ==== Makefile ====
# Verilator flow for the control-clock slice

VERILATOR   ?= verilator
TOP         ?= tb_hl_ctrl
FILE_LIST   ?= list.f
OBJ_DIR     ?= obj_dir
LINT_FLAGS  ?= --lint-only --timing
SIM_FLAGS   ?= --binary --timing --assert
EXTRA_FLAGS ?=

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(EXTRA_FLAGS) -f $(FILE_LIST) --top-module $(TOP)

# the simulator exits non-zero on any failing run
sim:
	$(VERILATOR) $(SIM_FLAGS) $(EXTRA_FLAGS) -f $(FILE_LIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_hl_ctrl.sv ====
//////////////////////////////////////////////////////////////////////
// directed testbench for the control-clock slice
// drives host commands and status levels, checks against a local model
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_hl_ctrl;

  import hl_pkg::*;

  // whole sequence runs in under 200 cycles
  localparam int MAX_CYCLES = 2000;

  logic        clk_ctrl;
  logic        reset_i;
  logic        cmd_rqst_i;
  logic [5:0]  cmd_addr_i;
  logic [31:0] cmd_data_i;
  logic        cmd_ptt_i;
  logic        cmd_requires_resp_i;
  logic        io_tx_inhibit_i;
  logic        io_alternate_mac_i;
  logic        rxclip_i;
  logic        rxgoodlvl_i;
  logic        run_i;
  logic        tx_on_o;
  logic [47:0] local_mac_o;
  logic [31:0] static_ip_o;
  logic [7:0]  eeprom_config_o;
  logic [39:0] resp_o;
  logic        resp_rqst_o;
  logic        io_led_run_o;

  // reference model state
  logic [31:0] rng_state;
  logic [31:0] exp_ip;
  logic [15:0] exp_alt_mac;
  logic [7:0]  exp_cfg;
  logic        exp_tx;
  logic        exp_clip;
  logic        exp_good;
  logic        exp_run;
  int          cycle_count = 0;

  tb_clk_gen clk_gen_i (
    .clk_ctrl (clk_ctrl),
    .reset_o  (reset_i)
  );

  hl_ctrl_top dut_i (.*);

  //////////////////////////////////////////////////////////////////////
  // helpers

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic next_word(output logic [31:0] w);
    rng_state = xorshift32(rng_state);
    w = rng_state;
  endtask

  function automatic logic [47:0] expected_mac();
    logic [47:0] mac;
    mac = MAC_BASE;
    if (exp_cfg[6]) begin
      mac[15:0] = exp_alt_mac;
    end else begin
      mac[1] = ~io_alternate_mac_i;
    end
    return mac;
  endfunction

  function automatic logic [39:0] expected_resp(input logic [5:0] addr, input logic ptt,
                                                input logic [7:0] cfg);
    logic [39:0] w;
    w = '0;
    w[39]    = ptt;
    w[37:32] = addr;
    w[31]    = exp_clip;
    w[30]    = exp_good;
    w[29]    = exp_tx;
    w[28]    = exp_run;
    w[23:16] = 8'd68;
    w[15:8]  = 8'd4;
    w[7:0]   = cfg;
    return w;
  endfunction

  task automatic abort_run();
    $display("tests failed");
    $fatal(1, "run stopped at %0t ns", $time);
  endtask

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                             input string what);
    assert (got === exp) else begin
      $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_config();
    check_value(64'(static_ip_o), 64'(exp_ip), "static_ip_o");
    check_value(64'(eeprom_config_o), 64'(exp_cfg), "eeprom_config_o");
    check_value(64'(local_mac_o), 64'(expected_mac()), "local_mac_o");
  endtask

  task automatic apply_write(input logic [5:0] addr, input logic [31:0] data);
    if (addr == ADDR_STATIC_IP) begin
      exp_ip = data;
    end else if (addr == ADDR_MAC_CFG) begin
      exp_alt_mac = data[31:16];
      exp_cfg     = data[15:8];
    end else if (addr == ADDR_CLR_STATUS) begin
      exp_clip = 1'b0;
      exp_good = 1'b0;
    end
  endtask

  // one-cycle strobe, returns on the falling edge after it was taken
  task automatic issue_cmd(input logic [5:0] addr, input logic [31:0] data,
                           input logic ptt, input logic need_resp);
    @(negedge clk_ctrl);
    cmd_rqst_i          = 1'b1;
    cmd_addr_i          = addr;
    cmd_data_i          = data;
    cmd_ptt_i           = ptt;
    cmd_requires_resp_i = need_resp;
    @(negedge clk_ctrl);
    cmd_rqst_i          = 1'b0;
    cmd_requires_resp_i = 1'b0;
    exp_tx = ptt & ~io_tx_inhibit_i;
  endtask

  task automatic write_and_check(input logic [5:0] addr, input logic [31:0] data);
    issue_cmd(addr, data, 1'b0, 1'b0);
    @(negedge clk_ctrl);
    apply_write(addr, data);
    check_config();
  endtask

  task automatic request_with_resp(input logic [5:0] addr, input logic [31:0] data,
                                   input logic ptt);
    logic [7:0]  cfg_before;
    logic [39:0] expected;
    cfg_before = exp_cfg;
    issue_cmd(addr, data, ptt, 1'b1);
    check_value(64'(resp_rqst_o), 64'(1'b0), "resp_rqst_o one cycle after request");
    // response is captured on the same edge that applies a write or clear
    expected = expected_resp(addr, ptt, cfg_before);
    @(negedge clk_ctrl);
    check_value(64'(resp_rqst_o), 64'(1'b1), "resp_rqst_o two cycles after request");
    check_value(64'(resp_o), 64'(expected), "resp_o");
    apply_write(addr, data);
    @(negedge clk_ctrl);
    check_value(64'(resp_rqst_o), 64'(1'b0), "resp_rqst_o three cycles after request");
    check_config();
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests

  task automatic test_reset_defaults();
    @(negedge clk_ctrl);
    check_value(64'(tx_on_o), 64'(1'b0), "tx_on_o after reset");
    check_value(64'(resp_rqst_o), 64'(1'b0), "resp_rqst_o after reset");
    check_config();
    io_alternate_mac_i = 1'b1;
    @(negedge clk_ctrl);
    check_config();
    io_alternate_mac_i = 1'b0;
    @(negedge clk_ctrl);
    check_config();
  endtask

  task automatic test_config_writes();
    logic [31:0] word;
    next_word(word);
    write_and_check(ADDR_STATIC_IP, word);
    // config bit 6 sits at data bit 14
    next_word(word);
    word[14] = 1'b1;
    write_and_check(ADDR_MAC_CFG, word);
    check_value(64'(local_mac_o), 64'({MAC_BASE[47:16], word[31:16]}), "alternate MAC");
    next_word(word);
    word[14] = 1'b0;
    write_and_check(ADDR_MAC_CFG, word);
    next_word(word);
    write_and_check(6'h15, word);
    @(negedge clk_ctrl);
    check_config();
  endtask

  task automatic test_tx_enable();
    issue_cmd(6'h01, 32'h0, 1'b1, 1'b0);
    check_value(64'(tx_on_o), 64'(1'b1), "tx_on_o after ptt request");
    io_tx_inhibit_i = 1'b1;
    @(negedge clk_ctrl);
    check_value(64'(tx_on_o), 64'(1'b0), "tx_on_o under inhibit");
    io_tx_inhibit_i = 1'b0;
    @(negedge clk_ctrl);
    check_value(64'(tx_on_o), 64'(1'b1), "tx_on_o after inhibit release");
    issue_cmd(6'h01, 32'h0, 1'b0, 1'b0);
    check_value(64'(tx_on_o), 64'(1'b0), "tx_on_o after ptt cleared");
  endtask

  task automatic test_response();
    logic [31:0] word;
    next_word(word);
    request_with_resp(6'h12, word, 1'b1);
    next_word(word);
    request_with_resp(ADDR_MAC_CFG, word, 1'b0);
    issue_cmd(6'h07, word, 1'b0, 1'b0);
    check_value(64'(resp_rqst_o), 64'(1'b0), "resp_rqst_o without response");
    repeat (3) begin
      @(negedge clk_ctrl);
      check_value(64'(resp_rqst_o), 64'(1'b0), "resp_rqst_o without response");
    end
  endtask

  task automatic test_sticky_status();
    run_i       = 1'b1;
    rxclip_i    = 1'b1;
    rxgoodlvl_i = 1'b1;
    repeat (3) @(negedge clk_ctrl);
    rxclip_i    = 1'b0;
    rxgoodlvl_i = 1'b0;
    repeat (5) @(negedge clk_ctrl);
    exp_clip = 1'b1;
    exp_good = 1'b1;
    exp_run  = 1'b1;
    check_value(64'(io_led_run_o), 64'(1'b1), "io_led_run_o");
    request_with_resp(6'h00, 32'h0, 1'b0);
    request_with_resp(ADDR_CLR_STATUS, 32'h0, 1'b0);
    // flags read back clear once the clear has landed
    request_with_resp(6'h00, 32'h0, 1'b0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // timeout and main sequence

  always @(posedge clk_ctrl) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
      abort_run();
    end
  end

  initial begin
    cmd_rqst_i          = 1'b0;
    cmd_addr_i          = '0;
    cmd_data_i          = '0;
    cmd_ptt_i           = 1'b0;
    cmd_requires_resp_i = 1'b0;
    io_tx_inhibit_i     = 1'b0;
    io_alternate_mac_i  = 1'b0;
    rxclip_i            = 1'b0;
    rxgoodlvl_i         = 1'b0;
    run_i               = 1'b0;
    rng_state           = 32'ha125;
    exp_ip              = '0;
    exp_alt_mac         = '0;
    exp_cfg             = '0;
    exp_tx              = 1'b0;
    exp_clip            = 1'b0;
    exp_good            = 1'b0;
    exp_run             = 1'b0;
    @(negedge reset_i);
    test_reset_defaults();
    test_config_writes();
    test_tx_enable();
    test_response();
    test_sticky_status();
    $display("all tests passed");
    $finish;
  end

endmodule

// ==== tb_clk_gen.sv ====
//////////////////////////////////////////////////////////////////////
// clock and reset source for the control-clock testbench
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_clk_gen (
  output logic clk_ctrl,
  output logic reset_o
);

  // 100 ns period
  localparam int HALF_PERIOD  = 50;
  localparam int RESET_CYCLES = 2;

  initial begin
    clk_ctrl = 1'b0;
    forever #HALF_PERIOD clk_ctrl = ~clk_ctrl;
  end

  // release on a falling edge, away from the sampling edge
  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_ctrl);
    @(negedge clk_ctrl);
    reset_o = 1'b0;
  end

endmodule

// ==== hl_ctrl_top.sv ====
//////////////////////////////////////////////////////////////////////
// control-clock top level of the radio core
// ties command decode, config registers, status and response together
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module hl_ctrl_top (
  input  logic                          clk_ctrl,
  input  logic                          reset_i,
  // host command
  input  logic                          cmd_rqst_i,
  input  logic [hl_pkg::CMD_ADDR_W-1:0] cmd_addr_i,
  input  logic [hl_pkg::CMD_DATA_W-1:0] cmd_data_i,
  input  logic                          cmd_ptt_i,
  input  logic                          cmd_requires_resp_i,
  // board io
  input  logic                          io_tx_inhibit_i,
  input  logic                          io_alternate_mac_i,
  // levels from other clock domains
  input  logic                          rxclip_i,
  input  logic                          rxgoodlvl_i,
  input  logic                          run_i,
  // outputs
  output logic                          tx_on_o,
  output logic [hl_pkg::MAC_W-1:0]      local_mac_o,
  output logic [hl_pkg::CMD_DATA_W-1:0] static_ip_o,
  output logic [7:0]                    eeprom_config_o,
  output logic [hl_pkg::RESP_W-1:0]     resp_o,
  output logic                          resp_rqst_o,
  output logic                          io_led_run_o
);

  import hl_pkg::*;

  logic                  ip_we;
  logic                  mac_cfg_we;
  logic                  clr_status;
  cmd_word_u             cmd_word;
  logic                  resp_load;
  logic [CMD_ADDR_W-1:0] resp_addr;
  logic                  resp_ptt;
  logic                  clip_sticky;
  logic                  goodlvl_sticky;

  cmd_ctrl cmd_ctrl_i (
    .clk_ctrl            (clk_ctrl),
    .reset_i             (reset_i),
    .cmd_rqst_i          (cmd_rqst_i),
    .cmd_addr_i          (cmd_addr_i),
    .cmd_data_i          (cmd_data_i),
    .cmd_ptt_i           (cmd_ptt_i),
    .cmd_requires_resp_i (cmd_requires_resp_i),
    .io_tx_inhibit_i     (io_tx_inhibit_i),
    .ip_we_o             (ip_we),
    .mac_cfg_we_o        (mac_cfg_we),
    .clr_status_o        (clr_status),
    .cmd_word_o          (cmd_word),
    .resp_load_o         (resp_load),
    .resp_addr_o         (resp_addr),
    .resp_ptt_o          (resp_ptt),
    .tx_on_o             (tx_on_o)
  );

  cfg_regs cfg_regs_i (
    .clk_ctrl           (clk_ctrl),
    .reset_i            (reset_i),
    .ip_we_i            (ip_we),
    .mac_cfg_we_i       (mac_cfg_we),
    .cmd_word_i         (cmd_word),
    .io_alternate_mac_i (io_alternate_mac_i),
    .static_ip_o        (static_ip_o),
    .eeprom_config_o    (eeprom_config_o),
    .local_mac_o        (local_mac_o)
  );

  // run level drives the LED directly
  status_monitor status_monitor_i (
    .clk_ctrl         (clk_ctrl),
    .reset_i          (reset_i),
    .rxclip_i         (rxclip_i),
    .rxgoodlvl_i      (rxgoodlvl_i),
    .run_i            (run_i),
    .clr_status_i     (clr_status),
    .clip_sticky_o    (clip_sticky),
    .goodlvl_sticky_o (goodlvl_sticky),
    .run_sync_o       (io_led_run_o)
  );

  resp_builder resp_builder_i (
    .clk_ctrl         (clk_ctrl),
    .reset_i          (reset_i),
    .resp_load_i      (resp_load),
    .resp_addr_i      (resp_addr),
    .resp_ptt_i       (resp_ptt),
    .tx_on_i          (tx_on_o),
    .clip_sticky_i    (clip_sticky),
    .goodlvl_sticky_i (goodlvl_sticky),
    .run_sync_i       (io_led_run_o),
    .eeprom_config_i  (eeprom_config_o),
    .resp_o           (resp_o),
    .resp_rqst_o      (resp_rqst_o)
  );

endmodule

// ==== resp_builder.sv ====
//////////////////////////////////////////////////////////////////////
// response word assembly for host commands
// one load gives a 40-bit status word and a single-cycle strobe
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module resp_builder (
  input  logic                          clk_ctrl,
  input  logic                          reset_i,
  input  logic                          resp_load_i,
  input  logic [hl_pkg::CMD_ADDR_W-1:0] resp_addr_i,
  input  logic                          resp_ptt_i,
  input  logic                          tx_on_i,
  input  logic                          clip_sticky_i,
  input  logic                          goodlvl_sticky_i,
  input  logic                          run_sync_i,
  input  logic [7:0]                    eeprom_config_i,
  output logic [hl_pkg::RESP_W-1:0]     resp_o,
  output logic                          resp_rqst_o
);

  import hl_pkg::*;

  logic [7:0]        echo_byte;
  logic [7:0]        status_byte;
  logic [RESP_W-1:0] resp_d;

  // ptt and echoed command address
  assign echo_byte   = {resp_ptt_i, 1'b0, resp_addr_i};
  // receiver and transmit state, low nibble spare
  assign status_byte = {clip_sticky_i, goodlvl_sticky_i, tx_on_i, run_sync_i, 4'h0};

  assign resp_d = {echo_byte, status_byte, VERSION_MAJOR, VERSION_MINOR, eeprom_config_i};

  //////////////////////////////////////////////////////////////////////
  // response register

  always_ff @(posedge clk_ctrl) begin
    if (reset_i) begin
      resp_o      <= '0;
      resp_rqst_o <= 1'b0;
    end else begin
      resp_rqst_o <= resp_load_i;
      // word is held until the next load
      if (resp_load_i) begin
        resp_o <= resp_d;
      end
    end
  end

  // request spacing upstream keeps response strobes single
  a_resp_single: assert property (
    @(posedge clk_ctrl) disable iff (reset_i)
    resp_rqst_o |=> !resp_rqst_o
  );

endmodule

// ==== status_monitor.sv ====
//////////////////////////////////////////////////////////////////////
// receiver status and run level brought onto the control clock
// clip and good-level stay set until the host clears them
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module status_monitor (
  input  logic clk_ctrl,
  input  logic reset_i,
  input  logic rxclip_i,
  input  logic rxgoodlvl_i,
  input  logic run_i,
  input  logic clr_status_i,
  output logic clip_sticky_o,
  output logic goodlvl_sticky_o,
  output logic run_sync_o
);

  // bit 2 run, bit 1 good level, bit 0 clip
  logic [2:0] meta_q;
  logic [2:0] sync_q;

  //////////////////////////////////////////////////////////////////////
  // two-flop level synchronizers

  always_ff @(posedge clk_ctrl) begin
    if (reset_i) begin
      meta_q <= '0;
      sync_q <= '0;
    end else begin
      meta_q <= {run_i, rxgoodlvl_i, rxclip_i};
      sync_q <= meta_q;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // sticky flags, clear has priority

  always_ff @(posedge clk_ctrl) begin
    if (reset_i) begin
      clip_sticky_o    <= 1'b0;
      goodlvl_sticky_o <= 1'b0;
      run_sync_o       <= 1'b0;
    end else begin
      if (clr_status_i) begin
        clip_sticky_o    <= 1'b0;
        goodlvl_sticky_o <= 1'b0;
      end else begin
        clip_sticky_o    <= clip_sticky_o | sync_q[0];
        goodlvl_sticky_o <= goodlvl_sticky_o | sync_q[1];
      end
      // same latency as the sticky bits
      run_sync_o <= sync_q[2];
    end
  end

  // a clear command always lands, even with the flag still asserted upstream
  a_clear_wins: assert property (
    @(posedge clk_ctrl) disable iff (reset_i)
    clr_status_i |=> !clip_sticky_o && !goodlvl_sticky_o
  );

endmodule

// ==== cfg_regs.sv ====
//////////////////////////////////////////////////////////////////////
// network configuration registers and local MAC selection
// loaded from command write strobes, read by the network side
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module cfg_regs (
  input  logic                          clk_ctrl,
  input  logic                          reset_i,
  input  logic                          ip_we_i,
  input  logic                          mac_cfg_we_i,
  input  hl_pkg::cmd_word_u             cmd_word_i,
  input  logic                          io_alternate_mac_i,
  output logic [hl_pkg::CMD_DATA_W-1:0] static_ip_o,
  output logic [7:0]                    eeprom_config_o,
  output logic [hl_pkg::MAC_W-1:0]      local_mac_o
);

  import hl_pkg::*;

  logic [15:0] alt_mac_q;
  logic [15:0] alt_mac_d;
  logic [7:0]  cfg_d;

  // next values, so the MAC follows a config write without extra delay
  always_comb begin
    alt_mac_d = alt_mac_q;
    cfg_d     = eeprom_config_o;
    if (mac_cfg_we_i) begin
      alt_mac_d = cmd_word_i.mac_cfg.alt_mac;
      cfg_d     = cmd_word_i.mac_cfg.eeprom_config;
    end
  end

  always_ff @(posedge clk_ctrl) begin
    if (reset_i) begin
      static_ip_o     <= '0;
      alt_mac_q       <= '0;
      eeprom_config_o <= '0;
      local_mac_o     <= '0;
    end else begin
      if (ip_we_i) begin
        static_ip_o <= cmd_word_i.ip;
      end
      alt_mac_q       <= alt_mac_d;
      eeprom_config_o <= cfg_d;
      if (cfg_d[CFG_ALT_MAC_BIT]) begin
        // vendor prefix kept, low two bytes from host
        local_mac_o <= {MAC_BASE[MAC_W-1:16], alt_mac_d};
      end else begin
        // strap pin selects between two board addresses
        local_mac_o <= {MAC_BASE[MAC_W-1:2], ~io_alternate_mac_i, MAC_BASE[0]};
      end
    end
  end

endmodule

// ==== cmd_ctrl.sv ====
//////////////////////////////////////////////////////////////////////
// host command decode on the control clock
// issues register write and clear strobes, response requests, tx enable
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module cmd_ctrl (
  input  logic                          clk_ctrl,
  input  logic                          reset_i,
  input  logic                          cmd_rqst_i,
  input  logic [hl_pkg::CMD_ADDR_W-1:0] cmd_addr_i,
  input  logic [hl_pkg::CMD_DATA_W-1:0] cmd_data_i,
  input  logic                          cmd_ptt_i,
  input  logic                          cmd_requires_resp_i,
  input  logic                          io_tx_inhibit_i,
  output logic                          ip_we_o,
  output logic                          mac_cfg_we_o,
  output logic                          clr_status_o,
  output hl_pkg::cmd_word_u             cmd_word_o,
  output logic                          resp_load_o,
  output logic [hl_pkg::CMD_ADDR_W-1:0] resp_addr_o,
  output logic                          resp_ptt_o,
  output logic                          tx_on_o
);

  import hl_pkg::*;

  logic hit_ip;
  logic hit_mac_cfg;
  logic hit_clr;
  logic ptt_q;
  logic ptt_d;

  //////////////////////////////////////////////////////////////////////
  // address decode

  assign hit_ip      = cmd_rqst_i && (cmd_addr_i == ADDR_STATIC_IP);
  assign hit_mac_cfg = cmd_rqst_i && (cmd_addr_i == ADDR_MAC_CFG);
  assign hit_clr     = cmd_rqst_i && (cmd_addr_i == ADDR_CLR_STATUS);

  // ptt as it will stand after this edge
  assign ptt_d = cmd_rqst_i ? cmd_ptt_i : ptt_q;

  //////////////////////////////////////////////////////////////////////
  // control state

  always_ff @(posedge clk_ctrl) begin
    if (reset_i) begin
      ip_we_o      <= 1'b0;
      mac_cfg_we_o <= 1'b0;
      clr_status_o <= 1'b0;
      resp_load_o  <= 1'b0;
      ptt_q        <= 1'b0;
      tx_on_o      <= 1'b0;
    end else begin
      ip_we_o      <= hit_ip;
      mac_cfg_we_o <= hit_mac_cfg;
      clr_status_o <= hit_clr;
      resp_load_o  <= cmd_rqst_i && cmd_requires_resp_i;
      ptt_q        <= ptt_d;
      // inhibit takes effect one cycle later, even without a request
      tx_on_o      <= ptt_d && !io_tx_inhibit_i;
    end
  end

  // payload captured with every request
  always_ff @(posedge clk_ctrl) begin
    if (cmd_rqst_i) begin
      cmd_word_o  <= cmd_word_u'(cmd_data_i);
      resp_addr_o <= cmd_addr_i;
      resp_ptt_o  <= cmd_ptt_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // checks

  // host side spaces its strobes at least two cycles apart
  a_rqst_spacing: assert property (
    @(posedge clk_ctrl) disable iff (reset_i)
    cmd_rqst_i |=> !cmd_rqst_i
  );

  // write and clear strobes are mutually exclusive
  a_strobe_onehot: assert property (
    @(posedge clk_ctrl) disable iff (reset_i)
    $onehot0({ip_we_o, mac_cfg_we_o, clr_status_o})
  );

endmodule

// ==== hl_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// shared constants and command word type for the control-clock slice
// imported by the control, config, status and response blocks
//////////////////////////////////////////////////////////////////////

package hl_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths

  localparam int CMD_ADDR_W = 6;
  localparam int CMD_DATA_W = 32;
  localparam int RESP_W     = 40;
  localparam int MAC_W      = 48;

  //////////////////////////////////////////////////////////////////////
  // command addresses handled on the control clock

  // data word carries the fixed IP address
  localparam logic [CMD_ADDR_W-1:0] ADDR_STATIC_IP  = 6'h3a;
  // data word carries alternate MAC tail and EEPROM config byte
  localparam logic [CMD_ADDR_W-1:0] ADDR_MAC_CFG    = 6'h3b;
  // clears sticky receiver clip and good-level flags
  localparam logic [CMD_ADDR_W-1:0] ADDR_CLR_STATUS = 6'h3c;

  //////////////////////////////////////////////////////////////////////
  // identity

  // board MAC 00:1c:c0:a2:13:dd
  localparam logic [MAC_W-1:0] MAC_BASE = 48'h00_1c_c0_a2_13_dd;

  localparam logic [7:0] VERSION_MAJOR = 8'd68;
  localparam logic [7:0] VERSION_MINOR = 8'd4;

  // config byte bit that swaps in the alternate MAC tail
  localparam int CFG_ALT_MAC_BIT = 6;

  //////////////////////////////////////////////////////////////////////
  // command data word, decoded per address

  typedef struct packed {
    logic [15:0] alt_mac;
    logic [7:0]  eeprom_config;
    logic [7:0]  reserved;
  } mac_cfg_t;

  typedef union packed {
    logic [CMD_DATA_W-1:0] ip;
    mac_cfg_t              mac_cfg;
  } cmd_word_u;

endpackage
